// File: Makefile
# Verilator flow for the decode-to-execute slice

VERILATOR ?= verilator
TOP       ?= decodeExecTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) cpu_defs.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and PC width
`define DATA_W 32

// Register index width, 32 general registers
`define REG_ADDR_W 5

// PC held by the pipeline registers out of reset
`define RESET_PC 32'h0000_3000

// Exception handler entry, also marks an interrupt bubble
`define HANDLER_PC 32'h0000_4180

`endif

// File: project.f
+incdir+.
source/cpuIsaPkg.sv
source/cpuPipePkg.sv
source/regFile.sv
source/instrDecode.sv
source/hazardUnit.sv
source/idExReg.sv
source/execAlu.sv
source/decodeExecTop.sv
verif/decodeExecTb.sv

// File: source/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// Primary opcodes in instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f
	} opcodeE;

	// Function codes for opSpecial
	typedef enum logic [5:0] {
		fnAdd  = 6'h20,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	// R-type field layout
	typedef struct packed {
		opcodeE     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functE      funct;
	} rFmtS;

	// I-type field layout
	typedef struct packed {
		opcodeE      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFmtS;

	// One word, two views
	typedef union packed {
		rFmtS rFmt;
		iFmtS iFmt;
	} instrWord;

	// Check variants trap on signed overflow
	typedef enum logic [2:0] {
		aluAdd, aluAddCheck, aluSub, aluSubCheck, aluAnd, aluOr, aluSlt, aluLui
	} aluOpE;

	// Exception codes carried down the pipe
	typedef enum logic [4:0] {
		excInt = 5'd0,
		excRi  = 5'd10,
		excOv  = 5'd12
	} excCodeE;

endpackage

`default_nettype wire

// File: source/cpuPipePkg.sv
`default_nettype none

package cpuPipePkg;

	// Execute-stage operand source
	// Encodings 2 and 3 unused
	typedef enum logic [1:0] {
		regRead    = 2'd0,
		fromResult = 2'd1
	} fwdSelE;

	// Which sources the decode-stage instruction reads
	typedef struct packed {
		logic useRs;
		logic useRt;
		logic isBranch;  // compares in decode, so it may need a stall
	} srcUseS;

endpackage

`default_nettype wire

// File: source/decodeExecTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decodeExecTop import cpuIsaPkg::*; import cpuPipePkg::*; (
	input  wire logic               clk,
	input  wire logic               rstN,
	input  wire logic [`DATA_W-1:0] instr,
	input  wire logic [`DATA_W-1:0] pcD,
	input  wire logic               intReq,
	output logic                    stall,
	output logic                    branchTaken,
	output logic      [`DATA_W-1:0] branchTarget,
	output logic      [`DATA_W-1:0] result,
	output logic      [`DATA_W-1:0] resultPc,
	output cpuIsaPkg::excCodeE      resultExc,
	output logic                    retire
);

	// Decode stage
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] destReg;
	logic                   regWrite;
	cpuIsaPkg::aluOpE       aluOp;
	logic                   useImm;
	logic [`DATA_W-1:0]     extImm;
	srcUseS                 srcUse;
	logic                   bd;
	cpuIsaPkg::excCodeE     excCode;
	logic [`DATA_W-1:0]     rd1;
	logic [`DATA_W-1:0]     rd2;
	fwdSelE                 rd1Sel;
	fwdSelE                 rd2Sel;
	logic [1:0]             fwdValid;

	// Execute stage
	logic [`DATA_W-1:0]     pcE;
	logic [`DATA_W-1:0]     instrE;
	logic [`REG_ADDR_W-1:0] rsE;
	logic [`REG_ADDR_W-1:0] rtE;
	logic [`REG_ADDR_W-1:0] destRegE;
	logic                   regWriteE;
	cpuIsaPkg::aluOpE       aluOpE;
	logic                   useImmE;
	logic [`DATA_W-1:0]     extImmE;
	logic [`DATA_W-1:0]     rd1E;
	logic [`DATA_W-1:0]     rd2E;
	fwdSelE                 rd1SelE;
	fwdSelE                 rd2SelE;
	logic                   bdE;
	cpuIsaPkg::excCodeE     excCodeE;

	// Writeback
	logic                   wbEn;
	logic [`REG_ADDR_W-1:0] wbAddr;
	logic [`DATA_W-1:0]     wbData;

	// Result register feeds a branch source in decode
	assign fwdValid[0] = wbEn && (wbAddr != '0) && (wbAddr == rs);
	assign fwdValid[1] = wbEn && (wbAddr != '0) && (wbAddr == rt);

	regFile u_regFile (
		.clk(clk), .rstN(rstN),
		.raddr1(rs), .raddr2(rt), .rdata1(rd1), .rdata2(rd2),
		.wen(wbEn), .waddr(wbAddr), .wdata(wbData)
	);

	instrDecode u_instrDecode (
		.clk(clk), .rstN(rstN), .instr(instr), .pcD(pcD), .stall(stall),
		.rd1(rd1), .rd2(rd2), .fwdData(wbData), .fwdValid(fwdValid),
		.rs(rs), .rt(rt), .destReg(destReg), .regWrite(regWrite), .aluOp(aluOp),
		.useImm(useImm), .extImm(extImm), .srcUse(srcUse), .bd(bd), .excCode(excCode),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	hazardUnit u_hazardUnit (
		.rs(rs), .rt(rt), .srcUse(srcUse), .destE(destRegE), .regWriteE(regWriteE),
		.rd1Sel(rd1Sel), .rd2Sel(rd2Sel), .stall(stall)
	);

	idExReg u_idExReg (
		.clk(clk), .rstN(rstN), .stall(stall), .intReq(intReq),
		.pc(pcD), .instr(instr), .rs(rs), .rt(rt), .destReg(destReg),
		.regWrite(regWrite), .aluOp(aluOp), .useImm(useImm), .extImm(extImm),
		.rd1(rd1), .rd2(rd2), .rd1Sel(rd1Sel), .rd2Sel(rd2Sel), .bd(bd), .excCode(excCode),
		.pcE(pcE), .instrE(instrE), .rsE(rsE), .rtE(rtE), .destRegE(destRegE),
		.regWriteE(regWriteE), .aluOpE(aluOpE), .useImmE(useImmE), .extImmE(extImmE),
		.rd1E(rd1E), .rd2E(rd2E), .rd1SelE(rd1SelE), .rd2SelE(rd2SelE), .bdE(bdE),
		.excCodeE(excCodeE)
	);

	execAlu u_execAlu (
		.clk(clk), .rstN(rstN), .aluOpE(aluOpE), .useImmE(useImmE), .extImmE(extImmE),
		.rd1E(rd1E), .rd2E(rd2E), .rd1SelE(rd1SelE), .rd2SelE(rd2SelE),
		.destE(destRegE), .regWriteE(regWriteE), .pcE(pcE), .excCodeE(excCodeE),
		.instrE(instrE), .result(result), .resultPc(resultPc), .resultExc(resultExc),
		.retire(retire), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
	);

endmodule

`default_nettype wire

// File: source/execAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execAlu import cpuIsaPkg::*; import cpuPipePkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rstN,
	input  wire cpuIsaPkg::aluOpE       aluOpE,
	input  wire logic                   useImmE,
	input  wire logic [`DATA_W-1:0]     extImmE,
	input  wire logic [`DATA_W-1:0]     rd1E,
	input  wire logic [`DATA_W-1:0]     rd2E,
	input  wire fwdSelE                 rd1SelE,
	input  wire fwdSelE                 rd2SelE,
	input  wire logic [`REG_ADDR_W-1:0] destE,
	input  wire logic                   regWriteE,
	input  wire logic [`DATA_W-1:0]     pcE,
	input  wire cpuIsaPkg::excCodeE     excCodeE,
	input  wire logic [`DATA_W-1:0]     instrE,
	output logic      [`DATA_W-1:0]     result,
	output logic      [`DATA_W-1:0]     resultPc,
	output cpuIsaPkg::excCodeE          resultExc,
	output logic                        retire,
	output logic                        wbEn,
	output logic      [`REG_ADDR_W-1:0] wbAddr,
	output logic      [`DATA_W-1:0]     wbData
);

	localparam int msb = `DATA_W - 1;

	logic [`DATA_W-1:0] srcA;
	logic [`DATA_W-1:0] srcB;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluOut;
	logic [`DATA_W:0]   addX;
	logic [`DATA_W:0]   subX;
	logic               ovf;
	cpuIsaPkg::excCodeE excNext;

	////////////////////////////////////////////////////////////////////////////
	// Operand select and ALU
	////////////////////////////////////////////////////////////////////////////

	// A suppressed write leaves rd1E/rd2E holding the unchanged register
	assign srcA = (rd1SelE == fromResult && wbEn) ? wbData : rd1E;
	assign srcB = (rd2SelE == fromResult && wbEn) ? wbData : rd2E;
	assign opB  = useImmE ? extImmE : srcB;

	// One extra sign bit exposes signed overflow
	assign addX = {srcA[msb], srcA} + {opB[msb], opB};
	assign subX = {srcA[msb], srcA} - {opB[msb], opB};

	always_comb begin
		case (aluOpE)
			aluAdd, aluAddCheck: aluOut = addX[msb:0];
			aluSub, aluSubCheck: aluOut = subX[msb:0];
			aluAnd:              aluOut = srcA & opB;
			aluOr:               aluOut = srcA | opB;
			aluSlt:              aluOut = `DATA_W'($signed(srcA) < $signed(opB));
			default:             aluOut = {opB[15:0], 16'h0000};
		endcase
	end

	assign ovf = (aluOpE == aluAddCheck && (addX[`DATA_W] != addX[msb])) ||
		(aluOpE == aluSubCheck && (subX[`DATA_W] != subX[msb]));

	// Decode exception outranks overflow
	assign excNext = (excCodeE != excInt) ? excCodeE : (ovf ? excOv : excInt);

	////////////////////////////////////////////////////////////////////////////
	// Memory/writeback result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retire <= 1'b0;
			wbEn   <= 1'b0;
		end else begin
			// Interrupt bubble has instr and code zero, only its PC marks it
			retire <= (instrE != '0) || (excCodeE != excInt) || (pcE == `HANDLER_PC);
			wbEn   <= regWriteE && (excNext == excInt);
		end
	end

	always_ff @(posedge clk) begin
		wbData    <= aluOut;
		wbAddr    <= destE;
		resultPc  <= pcE;
		resultExc <= excNext;
	end

	assign result = wbData;

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module hazardUnit import cpuPipePkg::*; (
	input  wire logic [`REG_ADDR_W-1:0] rs,
	input  wire logic [`REG_ADDR_W-1:0] rt,
	input  wire srcUseS                 srcUse,
	input  wire logic [`REG_ADDR_W-1:0] destE,
	input  wire logic                   regWriteE,
	output fwdSelE                      rd1Sel,
	output fwdSelE                      rd2Sel,
	output logic                        stall
);

	logic prodLive;
	logic hitRs;
	logic hitRt;

	// Instruction in idExReg produces a real register
	assign prodLive = regWriteE && (destE != '0);

	assign hitRs = prodLive && srcUse.useRs && (rs == destE);
	assign hitRt = prodLive && srcUse.useRt && (rt == destE);

	// Chosen now and applied next cycle in execute
	assign rd1Sel = hitRs ? fromResult : regRead;
	assign rd2Sel = hitRt ? fromResult : regRead;

	// Branch compares in decode and waits for the result register
	assign stall = srcUse.isBranch && (hitRs || hitRt);

endmodule

`default_nettype wire

// File: source/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module idExReg import cpuIsaPkg::*; import cpuPipePkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rstN,
	input  wire logic                   stall,
	input  wire logic                   intReq,
	input  wire logic [`DATA_W-1:0]     pc,
	input  wire logic [`DATA_W-1:0]     instr,
	input  wire logic [`REG_ADDR_W-1:0] rs,
	input  wire logic [`REG_ADDR_W-1:0] rt,
	input  wire logic [`REG_ADDR_W-1:0] destReg,
	input  wire logic                   regWrite,
	input  wire cpuIsaPkg::aluOpE       aluOp,
	input  wire logic                   useImm,
	input  wire logic [`DATA_W-1:0]     extImm,
	input  wire logic [`DATA_W-1:0]     rd1,
	input  wire logic [`DATA_W-1:0]     rd2,
	input  wire fwdSelE                 rd1Sel,
	input  wire fwdSelE                 rd2Sel,
	input  wire logic                   bd,
	input  wire cpuIsaPkg::excCodeE     excCode,
	output logic      [`DATA_W-1:0]     pcE,
	output logic      [`DATA_W-1:0]     instrE,
	output logic      [`REG_ADDR_W-1:0] rsE,
	output logic      [`REG_ADDR_W-1:0] rtE,
	output logic      [`REG_ADDR_W-1:0] destRegE,
	output logic                        regWriteE,
	output cpuIsaPkg::aluOpE            aluOpE,
	output logic                        useImmE,
	output logic      [`DATA_W-1:0]     extImmE,
	output logic      [`DATA_W-1:0]     rd1E,
	output logic      [`DATA_W-1:0]     rd2E,
	output fwdSelE                      rd1SelE,
	output fwdSelE                      rd2SelE,
	output logic                        bdE,
	output cpuIsaPkg::excCodeE          excCodeE
);

	logic bubble;

	// Interrupt flush and stall both leave a bubble behind
	assign bubble = intReq || stall;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcE       <= `RESET_PC;
			instrE    <= '0;
			rsE       <= '0;
			rtE       <= '0;
			destRegE  <= '0;
			regWriteE <= 1'b0;
			aluOpE    <= aluAdd;
			useImmE   <= 1'b0;
			extImmE   <= '0;
			rd1E      <= '0;
			rd2E      <= '0;
			rd1SelE   <= regRead;
			rd2SelE   <= regRead;
			bdE       <= 1'b0;
			excCodeE  <= excInt;
		end else begin
			// Stall bubble keeps pc, bd and excCode for precise exceptions
			pcE       <= intReq ? `HANDLER_PC : pc;
			bdE       <= !intReq && bd;
			excCodeE  <= intReq ? excInt : excCode;
			instrE    <= bubble ? '0 : instr;
			rsE       <= bubble ? '0 : rs;
			rtE       <= bubble ? '0 : rt;
			destRegE  <= bubble ? '0 : destReg;
			regWriteE <= !bubble && regWrite;
			aluOpE    <= bubble ? aluAdd : aluOp;
			useImmE   <= !bubble && useImm;
			extImmE   <= bubble ? '0 : extImm;
			rd1E      <= bubble ? '0 : rd1;
			rd2E      <= bubble ? '0 : rd2;
			rd1SelE   <= bubble ? regRead : rd1Sel;
			rd2SelE   <= bubble ? regRead : rd2Sel;
		end
	end

	// Fetch re-presents a stalled word so the next edge captures it
	assert property (@(posedge clk) disable iff (!rstN)
		stall && !intReq |=> $stable(pc) && $stable(instr))
		else $error("idExReg: stalled instruction not held by fetch");

endmodule

`default_nettype wire

// File: source/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module instrDecode import cpuIsaPkg::*; import cpuPipePkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rstN,
	input  wire instrWord               instr,
	input  wire logic [`DATA_W-1:0]     pcD,
	input  wire logic                   stall,
	input  wire logic [`DATA_W-1:0]     rd1,
	input  wire logic [`DATA_W-1:0]     rd2,
	input  wire logic [`DATA_W-1:0]     fwdData,
	input  wire logic [1:0]             fwdValid,  // bit 0 rs, bit 1 rt
	output logic      [`REG_ADDR_W-1:0] rs,
	output logic      [`REG_ADDR_W-1:0] rt,
	output logic      [`REG_ADDR_W-1:0] destReg,
	output logic                        regWrite,
	output aluOpE                       aluOp,
	output logic                        useImm,
	output logic      [`DATA_W-1:0]     extImm,
	output srcUseS                      srcUse,
	output logic                        bd,
	output excCodeE                     excCode,
	output logic                        branchTaken,
	output logic      [`DATA_W-1:0]     branchTarget
);

	logic               zeroExt;
	logic               legal;
	logic               isBne;
	logic [`DATA_W-1:0] cmpA;
	logic [`DATA_W-1:0] cmpB;
	logic               prevBranch;

	assign rs = instr.rFmt.rs;
	assign rt = instr.rFmt.rt;

	////////////////////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		destReg  = instr.iFmt.rt;
		regWrite = 1'b1;
		aluOp    = aluAdd;
		useImm   = 1'b1;
		zeroExt  = 1'b0;
		srcUse   = '{useRs: 1'b1, useRt: 1'b0, isBranch: 1'b0};
		isBne    = 1'b0;
		legal    = 1'b1;
		case (instr.iFmt.opcode)
			opSpecial: begin
				destReg       = instr.rFmt.rd;
				useImm        = 1'b0;
				srcUse.useRt  = 1'b1;
				case (instr.rFmt.funct)
					fnAdd:   aluOp = aluAddCheck;
					fnAddu:  aluOp = aluAdd;
					fnSubu:  aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnSlt:   aluOp = aluSlt;
					// All-zero word is the nop, legal but writes nothing
					default: legal = (instr == '0);
				endcase
			end
			opAddi:  aluOp = aluAddCheck;
			opAddiu: aluOp = aluAdd;
			opOri: begin
				aluOp   = aluOr;
				zeroExt = 1'b1;
			end
			opLui: begin
				aluOp        = aluLui;
				zeroExt      = 1'b1;
				srcUse.useRs = 1'b0;
			end
			opBeq, opBne: begin
				regWrite        = 1'b0;
				useImm          = 1'b0;
				srcUse          = '{useRs: 1'b1, useRt: 1'b1, isBranch: 1'b1};
				isBne           = (instr.iFmt.opcode == opBne);
			end
			default: legal = 1'b0;
		endcase
		// Reserved word, nothing read, nothing written
		if (!legal || instr == '0) begin
			regWrite = 1'b0;
			srcUse   = '0;
		end
	end

	assign excCode = legal ? excInt : excRi;
	assign extImm  = zeroExt ? {{(`DATA_W-16){1'b0}}, instr.iFmt.imm} :
		{{(`DATA_W-16){instr.iFmt.imm[15]}}, instr.iFmt.imm};

	////////////////////////////////////////////////////////////////////////////
	// Branch compare and target
	////////////////////////////////////////////////////////////////////////////

	// Result register value wins when it writes a branch source
	assign cmpA = fwdValid[0] ? fwdData : rd1;
	assign cmpB = fwdValid[1] ? fwdData : rd2;

	// No redirect while stalled, operands still pending
	assign branchTaken  = srcUse.isBranch && !stall && ((cmpA == cmpB) != isBne);
	assign branchTarget = pcD + `DATA_W'(4) + {extImm[`DATA_W-3:0], 2'b00};

	// Delay slot follows the last accepted branch
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			prevBranch <= 1'b0;
		end else if (!stall) begin
			prevBranch <= srcUse.isBranch;
		end
	end

	assign bd = prevBranch;

	// Producer leaves idExReg after one cycle, so stall never repeats
	assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
		else $error("instrDecode: stall longer than one cycle");

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module regFile (
	input  wire logic                   clk,
	input  wire logic                   rstN,
	input  wire logic [`REG_ADDR_W-1:0] raddr1,
	input  wire logic [`REG_ADDR_W-1:0] raddr2,
	output logic      [`DATA_W-1:0]     rdata1,
	output logic      [`DATA_W-1:0]     rdata2,
	input  wire logic                   wen,
	input  wire logic [`REG_ADDR_W-1:0] waddr,
	input  wire logic [`DATA_W-1:0]     wdata
);

	localparam int numRegs = 1 << `REG_ADDR_W;

	logic [`DATA_W-1:0] regs [numRegs];

	// Register 0 never written
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through, decode sees this cycle's writeback
	assign rdata1 = (raddr1 == '0) ? '0 :
		(wen && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(wen && waddr == raddr2) ? wdata : regs[raddr2];

	// Writeback data must be resolved by the result register
	assert property (@(posedge clk) disable iff (!rstN) wen |-> !$isunknown(wdata))
		else $error("regFile: X on write data");

endmodule

`default_nettype wire

// File: verif/decodeExecTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decodeExecTb import cpuIsaPkg::*; ();

	localparam int halfPeriod  = 10;
	localparam int samplePoint = 9;   // just before the rising edge
	localparam int randLen     = 200;

	logic               clk;
	logic               rstN;
	logic [`DATA_W-1:0] instr;
	logic [`DATA_W-1:0] pcD;
	logic               intReq;
	logic               stall;
	logic               branchTaken;
	logic [`DATA_W-1:0] branchTarget;
	logic [`DATA_W-1:0] result;
	logic [`DATA_W-1:0] resultPc;
	excCodeE            resultExc;
	logic               retire;

	// Program image from 0x3000 upward with nop where nothing was placed
	logic [`DATA_W-1:0] progMem [0:2047];
	logic [`DATA_W-1:0] modelRegs [32];
	logic [`DATA_W-1:0] buildPc;
	logic [`DATA_W-1:0] intPc;
	logic [`DATA_W-1:0] endPc;
	integer             seed;
	int                 progLen;
	int                 cycles;
	int                 cycleLimit;
	int                 errCount;

	// Expected retirements in program order
	logic [`DATA_W-1:0] expPc [$];
	excCodeE            expExc [$];
	logic [`DATA_W-1:0] expData [$];
	logic               expHasData [$];
	int                 expCycle [$];

	decodeExecTop u_decodeExecTop (
		.clk(clk), .rstN(rstN), .instr(instr), .pcD(pcD), .intReq(intReq),
		.stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.result(result), .resultPc(resultPc), .resultExc(resultExc), .retire(retire)
	);

	always #(halfPeriod) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Error handling and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stopOnError();
		errCount++;
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compareData(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic comparePc(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic compareExc(input string name, input excCodeE got, input excCodeE exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp);
			stopOnError();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Encoders and program image
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [10:0] memIndex(input logic [`DATA_W-1:0] pc);
		logic [`DATA_W-1:0] off;
		off = pc - `RESET_PC;
		return off[12:2];
	endfunction

	function automatic logic [`DATA_W-1:0] rType(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		instrWord w;
		w.rFmt.opcode = opSpecial;
		w.rFmt.rs     = rs;
		w.rFmt.rt     = rt;
		w.rFmt.rd     = rd;
		w.rFmt.shamt  = '0;
		w.rFmt.funct  = functE'(fn);
		return w;
	endfunction

	function automatic logic [`DATA_W-1:0] iType(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		instrWord w;
		w.iFmt.opcode = opcodeE'(op);
		w.iFmt.rs     = rs;
		w.iFmt.rt     = rt;
		w.iFmt.imm    = imm;
		return w;
	endfunction

	task automatic emit(input logic [`DATA_W-1:0] w);
		progMem[memIndex(buildPc)] = w;
		buildPc = buildPc + 32'd4;
		progLen++;
	endtask

	// Directed part covering chains, branch stalls, overflow, reserved words and the interrupt
	task automatic buildDirected();
		buildPc = `RESET_PC;
		emit(iType(opAddiu, 5'd1, 5'd0, 16'd5));
		emit(iType(opAddiu, 5'd2, 5'd1, 16'd7));
		emit(rType(fnAddu, 5'd3, 5'd1, 5'd2));
		emit(rType(fnSubu, 5'd4, 5'd3, 5'd1));
		emit(rType(fnAnd, 5'd5, 5'd4, 5'd3));
		emit(rType(fnOr, 5'd6, 5'd5, 5'd2));
		emit(rType(fnSlt, 5'd7, 5'd1, 5'd6));
		emit(iType(opLui, 5'd8, 5'd0, 16'h7fff));
		emit(iType(opOri, 5'd8, 5'd8, 16'hffff));
		// Taken beq right behind its producer
		emit(iType(opBeq, 5'd8, 5'd8, 16'd2));
		emit(iType(opAddiu, 5'd9, 5'd0, 16'd1));
		emit(iType(opAddiu, 5'd9, 5'd0, 16'd2));
		emit(iType(opAddiu, 5'd10, 5'd0, 16'd3));
		// Not taken
		emit(iType(opBne, 5'd10, 5'd10, 16'd5));
		emit(iType(opAddiu, 5'd11, 5'd10, 16'd1));
		emit(rType(fnAdd, 5'd12, 5'd8, 5'd8));
		emit(iType(opAddi, 5'd13, 5'd8, 16'd1));
		emit(rType(fnAddu, 5'd14, 5'd12, 5'd13));
		emit({6'h3f, 26'h0123456});
		emit(rType(6'h3f, 5'd3, 5'd1, 5'd2));
		emit(iType(opAddiu, 5'd15, 5'd0, 16'hffff));
		emit(iType(opBeq, 5'd14, 5'd15, 16'd1));
		emit(rType(fnOr, 5'd16, 5'd15, 5'd0));
		// This one sits in decode when intReq fires
		intPc = buildPc;
		emit(iType(opAddiu, 5'd17, 5'd0, 16'd9));
	endtask

	// Random part at the handler where a branch never lands in a delay slot
	task automatic buildRandom();
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0]  kind;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rc;
		logic [15:0] off;
		logic        prevBr;
		prevBr  = 1'b0;
		buildPc = `HANDLER_PC;
		for (int i = 0; i < randLen; i++) begin
			r    = $random(seed);
			r2   = $random(seed);
			kind = r[3:0];
			ra   = {2'b00, r[6:4]};
			rb   = {2'b00, r[9:7]};
			rc   = {2'b00, r[12:10]};
			off  = {14'd0, r2[1:0]} + 16'd1;
			// Plain addiu at the handler entry because a bubble there would retire
			if (i == 0)
				kind = 4'd6;
			if (prevBr && (kind == 4'd10 || kind == 4'd11))
				kind = 4'd0;
			case (kind)
				4'd0:  emit(rType(fnAddu, rc, ra, rb));
				4'd1:  emit(rType(fnSubu, rc, ra, rb));
				4'd2:  emit(rType(fnAdd, rc, ra, rb));
				4'd3:  emit(rType(fnAnd, rc, ra, rb));
				4'd4:  emit(rType(fnOr, rc, ra, rb));
				4'd5:  emit(rType(fnSlt, rc, ra, rb));
				4'd6:  emit(iType(opAddiu, rb, ra, r2[15:0]));
				4'd7:  emit(iType(opAddi, rb, ra, r2[15:0]));
				4'd8:  emit(iType(opOri, rb, ra, r2[15:0]));
				4'd9:  emit(iType(opLui, rb, ra, r2[15:0]));
				4'd10: emit(iType(opBeq, rb, ra, off));
				4'd11: emit(iType(opBne, rb, ra, off));
				4'd12: emit({6'h3f, r2[25:0]});
				4'd13: emit(rType(fnAdd, rc, ra, rb));
				4'd14: emit(iType(opLui, rb, 5'd0, r2[31:16]));
				default: emit(iType(opAddi, rb, ra, r2[15:0]));
			endcase
			prevBr = (kind == 4'd10 || kind == 4'd11);
		end
		endPc = buildPc;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Sequential execution of one accepted word
	function automatic void execModel(input instrWord w, input logic [`DATA_W-1:0] pc,
		output logic [`DATA_W-1:0] res, output excCodeE exc, output logic [4:0] dst,
		output logic isBr, output logic taken, output logic [`DATA_W-1:0] target);
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] sImm;
		logic               wr;
		a      = modelRegs[w.iFmt.rs];
		b      = modelRegs[w.iFmt.rt];
		sImm   = {{16{w.iFmt.imm[15]}}, w.iFmt.imm};
		res    = '0;
		exc    = excInt;
		dst    = w.iFmt.rt;
		isBr   = 1'b0;
		taken  = 1'b0;
		target = pc + 32'd4 + {sImm[29:0], 2'b00};
		wr     = 1'b1;
		case (w.iFmt.opcode)
			opSpecial: begin
				dst = w.rFmt.rd;
				case (w.rFmt.funct)
					fnAdd: begin
						res = a + b;
						// Same-sign operands with a sum of the other sign
						if (a[31] == b[31] && res[31] != a[31])
							exc = excOv;
					end
					fnAddu: res = a + b;
					fnSubu: res = a - b;
					fnAnd:  res = a & b;
					fnOr:   res = a | b;
					fnSlt:  res = {31'd0, $signed(a) < $signed(b)};
					default: begin
						wr = 1'b0;
						if (w != '0)
							exc = excRi;
					end
				endcase
			end
			opAddi: begin
				res = a + sImm;
				if (a[31] == sImm[31] && res[31] != a[31])
					exc = excOv;
			end
			opAddiu: res = a + sImm;
			opOri:   res = a | {16'd0, w.iFmt.imm};
			opLui:   res = {w.iFmt.imm, 16'd0};
			opBeq, opBne: begin
				wr    = 1'b0;
				isBr  = 1'b1;
				res   = a + b;
				taken = (a == b) != (w.iFmt.opcode == opBne);
			end
			default: begin
				wr  = 1'b0;
				exc = excRi;
			end
		endcase
		// Trapped instruction leaves its destination alone
		if (wr && exc == excInt && dst != 5'd0)
			modelRegs[dst] = res;
	endfunction

	task automatic pushExpect(input logic [`DATA_W-1:0] pc, input excCodeE exc,
		input logic [`DATA_W-1:0] data, input logic hasData);
		expPc.push_back(pc);
		expExc.push_back(exc);
		expData.push_back(data);
		expHasData.push_back(hasData);
		// Accepted at the next edge and retired one edge later
		expCycle.push_back(cycles + 2);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Retire checker and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic [`DATA_W-1:0] ePc;
		excCodeE            eExc;
		logic [`DATA_W-1:0] eData;
		logic               eHas;
		int                 eCycle;
		if (rstN && retire) begin
			if (expPc.size() == 0) begin
				$display("Retire at time %0t with no instruction outstanding", $time);
				stopOnError();
			end else begin
				ePc    = expPc.pop_front();
				eExc   = expExc.pop_front();
				eData  = expData.pop_front();
				eHas   = expHasData.pop_front();
				eCycle = expCycle.pop_front();
				if (cycles != eCycle) begin
					$display("MISMATCH time %0t retire cycle got %0d expected %0d", $time,
						cycles, eCycle);
					stopOnError();
				end
				comparePc("resultPc", resultPc, ePc);
				compareExc("resultExc", resultExc, eExc);
				if (eHas)
					compareData("result", result, eData);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, pipeline did not drain", cycles);
			stopOnError();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Fetch stand-in and interrupt source
	////////////////////////////////////////////////////////////////////////////

	initial begin
		instrWord           w;
		logic [`DATA_W-1:0] pc;
		logic [`DATA_W-1:0] redirPc;
		logic [`DATA_W-1:0] res;
		logic [`DATA_W-1:0] target;
		excCodeE            exc;
		logic [4:0]         dst;
		logic [4:0]         prevDest;
		logic               isBr;
		logic               taken;
		logic               pendRedir;
		logic               prevLive;
		logic               intDone;
		logic               expStall;
		clk        = 1'b0;
		rstN       = 1'b0;
		instr      = '0;
		pcD        = `RESET_PC;
		intReq     = 1'b0;
		seed       = 28;
		cycles     = 0;
		errCount   = 0;
		progLen    = 0;
		cycleLimit = 100000;
		for (int i = 0; i < 2048; i++)
			progMem[i] = '0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		buildDirected();
		buildRandom();
		cycleLimit = progLen * 4 + 50;

		repeat (5) @(negedge clk);
		rstN      = 1'b1;
		pc        = `RESET_PC;
		pendRedir = 1'b0;
		prevLive  = 1'b0;
		prevDest  = '0;
		redirPc   = '0;
		intDone   = 1'b0;

		while (pc < endPc) begin
			@(negedge clk);
			w      = progMem[memIndex(pc)];
			instr  = w;
			pcD    = pc;
			intReq = !intDone && (pc == intPc);
			#(samplePoint);
			// Branch waits one cycle on a producer still in execute
			isBr     = (w.iFmt.opcode == opBeq) || (w.iFmt.opcode == opBne);
			expStall = isBr && prevLive && (prevDest != 5'd0) &&
				(w.iFmt.rs == prevDest || w.iFmt.rt == prevDest);
			compareFlag("stall", stall, expStall);
			if (intReq) begin
				// Decode word dropped and the handler bubble retires instead
				pushExpect(`HANDLER_PC, excInt, '0, 1'b0);
				intDone   = 1'b1;
				pc        = `HANDLER_PC;
				pendRedir = 1'b0;
				prevLive  = 1'b0;
			end else if (expStall) begin
				prevLive = 1'b0;
			end else begin
				execModel(w, pc, res, exc, dst, isBr, taken, target);
				compareFlag("branchTaken", branchTaken, isBr && taken);
				if (isBr && taken)
					comparePc("branchTarget", branchTarget, target);
				if (w != '0)
					pushExpect(pc, exc, res, (exc == excInt) && !isBr);
				prevLive = (exc != excRi) && !isBr && (w != '0);
				prevDest = dst;
				// Delay slot first and then the target
				if (pendRedir)
					pc = redirPc;
				else
					pc = pc + 32'd4;
				pendRedir = isBr && taken;
				redirPc   = target;
			end
		end

		// Drain with nops
		@(negedge clk);
		instr  = '0;
		pcD    = endPc;
		intReq = 1'b0;
		while (expPc.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);

		if (errCount == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stopOnError();
		end
	end

endmodule

`default_nettype wire
